// ==== source/ptw_settings.svh ====
// widths, level count and pmp region count for the sv39 page table walker
`ifndef PTW_SETTINGS_SVH
`define PTW_SETTINGS_SVH

// ------------------------------
// address and page number widths
// ------------------------------
`define PTW_VLEN 39
`define PTW_PLEN 56
`define PTW_PPNW 44

// address space identifier from satp
`define PTW_ASIDW 16

// ------------------------------
// walk and protection sizing
// ------------------------------
// sv39 walks at most three levels
`define PTW_LEVELS 3

// top-of-range regions checked on page table reads
`define PTW_PMP_ENTRIES 4

`endif

// ==== source/ptw_pkg.sv ====
// packed types for page table entries, tlb ports, the cache port and pmp regions
`include "ptw_settings.svh"

package ptw_pkg;

    // ------------------------------
    // page table entry, sv39 layout
    // ------------------------------
    typedef struct packed {
        logic [9:0]           reserved;
        logic [`PTW_PPNW-1:0] ppn;
        logic [1:0]           rsw;
        logic                 d;
        logic                 a;
        logic                 g;
        logic                 u;
        logic                 x;
        logic                 w;
        logic                 r;
        logic                 v;
    } pte_t;

    // ------------------------------
    // tlb side
    // ------------------------------
    // lookup status from one tlb
    typedef struct packed {
        logic                 access;
        logic                 hit;
        logic [`PTW_VLEN-1:0] vaddr;
    } tlb_miss_t;

    typedef struct packed {
        logic                  valid;
        logic [26:0]           vpn;
        logic                  is_1g;
        logic                  is_2m;
        logic [`PTW_ASIDW-1:0] asid;
        pte_t                  content;
    } tlb_update_t;

    // ------------------------------
    // data cache port
    // ------------------------------
    typedef struct packed {
        logic                 req;
        logic [`PTW_PLEN-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [63:0] rdata;
    } mem_rsp_t;

    // tor region, addr holds the upper bound without its two low bits
    typedef struct packed {
        logic                   r;
        logic                   w;
        logic                   x;
        logic [`PTW_PLEN-3:0]   addr;
    } pmp_entry_t;

    // one-hot classification of a returned entry
    typedef struct packed {
        logic is_fault;
        logic is_leaf;
        logic is_pointer;
    } pte_verdict_t;

    typedef enum logic [$clog2(`PTW_LEVELS)-1:0] {
        LVL1,
        LVL2,
        LVL3
    } walk_lvl_t;

endpackage

// ==== source/pte_checker.sv ====
// page table entry classifier into invalid, pointer, permitted leaf or faulting leaf
`timescale 1ns/1ns
`include "ptw_settings.svh"

module pte_checker import ptw_pkg::*; (
    input  pte_t         pte_i,
    input  walk_lvl_t    lvl_i,
    input  logic         is_instr_i,
    input  logic         is_store_i,
    input  logic         mxr_i,
    output pte_verdict_t verdict_o
);

    always_comb begin : classify
        logic leaf;
        logic misaligned;
        logic reserved;
        logic perm_fault;

        // r or x marks a leaf, otherwise the entry points one level down
        leaf = pte_i.r || pte_i.x;

        // superpage page numbers must be zero below their level
        misaligned = (lvl_i == LVL1 && pte_i.ppn[17:0] != '0) ||
                     (lvl_i == LVL2 && pte_i.ppn[8:0] != '0);

        // write without read is a reserved encoding
        reserved = !pte_i.r && pte_i.w;

        // ------------------------------
        // leaf permission checks
        // ------------------------------
        if (is_instr_i) begin
            perm_fault = !pte_i.x || !pte_i.a;
        end else begin
            // execute-only pages are readable only with mxr
            perm_fault = !pte_i.a || !(pte_i.r || (mxr_i && pte_i.x));
            perm_fault = perm_fault || (is_store_i && (!pte_i.w || !pte_i.d));
        end

        // ------------------------------
        // verdict
        // ------------------------------
        // a pointer carries no permission bits and needs a level below it
        verdict_o.is_pointer = pte_i.v && !pte_i.r && !pte_i.w && !pte_i.x &&
                               (lvl_i != LVL3);
        verdict_o.is_leaf    = pte_i.v && leaf && !reserved && !perm_fault && !misaligned;
        verdict_o.is_fault   = !pte_i.v || reserved ||
                               (leaf && (perm_fault || misaligned)) ||
                               (!leaf && lvl_i == LVL3);

        if (!$isunknown({pte_i, lvl_i, is_instr_i, is_store_i, mxr_i})) begin
            verdict_onehot: assert ($onehot(verdict_o))
                else $error("pte verdict is not one-hot: %b", verdict_o);
        end
    end

endmodule

// ==== source/pmp_checker.sv ====
// top-of-range pmp check for page table reads in supervisor mode
`timescale 1ns/1ns
`include "ptw_settings.svh"

module pmp_checker import ptw_pkg::*; (
    input  logic [`PTW_PLEN-1:0]                  addr_i,
    input  pmp_entry_t [`PTW_PMP_ENTRIES-1:0]     cfg_i,
    output logic                                  allow_o
);

    // region k spans [bound of k-1, bound of k), region 0 starts at zero
    always_comb begin : tor_scan
        logic [`PTW_PLEN-1:0] lo;
        logic [`PTW_PLEN-1:0] hi;
        logic                 matched;

        lo      = '0;
        matched = 1'b0;
        // unmatched reads pass in supervisor mode
        allow_o = 1'b1;

        for (int k = 0; k < `PTW_PMP_ENTRIES; k++) begin
            hi = {cfg_i[k].addr, 2'b00};
            // lowest matching region wins
            if (!matched && addr_i >= lo && addr_i < hi) begin
                matched = 1'b1;
                allow_o = cfg_i[k].r;
            end
            lo = hi;
        end
    end

endmodule

// ==== source/walk_sequencer.sv ====
// walk fsm with address registers, cache handshake, tlb updates and fault pulses
`timescale 1ns/1ns
`include "ptw_settings.svh"

module walk_sequencer import ptw_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  tlb_miss_t             itlb_miss_i,
    input  tlb_miss_t             dtlb_miss_i,
    input  logic                  en_instr_i,
    input  logic                  en_data_i,
    input  logic [`PTW_PPNW-1:0]  satp_ppn_i,
    input  logic [`PTW_ASIDW-1:0] asid_i,
    input  mem_rsp_t              mem_rsp_i,
    input  pte_verdict_t          verdict_i,
    input  logic                  allow_i,
    output mem_req_t              mem_req_o,
    output pte_t                  pte_o,
    output walk_lvl_t             lvl_o,
    output logic                  is_instr_o,
    output logic [`PTW_PLEN-1:0]  pptr_o,
    output tlb_update_t           itlb_update_o,
    output tlb_update_t           dtlb_update_o,
    output logic                  ptw_active_o,
    output logic                  ptw_error_o,
    output logic                  ptw_access_fault_o,
    output logic [`PTW_PLEN-1:0]  bad_paddr_o,
    output logic                  itlb_miss_o,
    output logic                  dtlb_miss_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR,
        PROPAGATE_ACCESS_ERROR
    } state_e;

    state_e                  state_q, state_d;
    walk_lvl_t               lvl_q, lvl_d;
    logic                    is_instr_q, is_instr_d;
    logic                    global_q, global_d;
    logic [`PTW_ASIDW-1:0]   asid_q, asid_d;
    logic [`PTW_VLEN-1:0]    vaddr_q, vaddr_d;
    logic [`PTW_PLEN-1:0]    pptr_q, pptr_d;

    // response is registered once before the checkers see it
    logic                    rvalid_q;
    logic [63:0]             rdata_q;

    pte_t                    pte;
    logic                    data_miss;
    logic                    instr_miss;
    logic                    itlb_valid;
    logic                    dtlb_valid;
    tlb_update_t             update_base;

    assign pte = pte_t'(rdata_q);

    // data misses win, and an instruction miss waits while the dtlb is busy
    assign data_miss  = en_data_i && dtlb_miss_i.access && !dtlb_miss_i.hit;
    assign instr_miss = en_instr_i && itlb_miss_i.access && !itlb_miss_i.hit &&
                        !dtlb_miss_i.access;

    assign mem_req_o.req  = (state_q == WAIT_GRANT);
    assign mem_req_o.addr = pptr_q;

    assign pte_o        = pte;
    assign lvl_o        = lvl_q;
    assign is_instr_o   = is_instr_q;
    assign pptr_o       = pptr_q;
    assign ptw_active_o = (state_q != IDLE);
    assign bad_paddr_o  = ptw_access_fault_o ? pptr_q : '0;

    // ------------------------------
    // tlb update
    // ------------------------------
    always_comb begin
        update_base           = '0;
        update_base.vpn       = vaddr_q[`PTW_VLEN-1:12];
        update_base.is_1g     = (lvl_q == LVL1);
        update_base.is_2m     = (lvl_q == LVL2);
        update_base.asid      = asid_q;
        update_base.content   = pte;
        // global if any level of the walk was global
        update_base.content.g = global_q || pte.g;

        itlb_update_o       = update_base;
        dtlb_update_o       = update_base;
        itlb_update_o.valid = itlb_valid;
        dtlb_update_o.valid = dtlb_valid;
    end

    // ------------------------------
    // walk fsm
    // ------------------------------
    always_comb begin
        state_d            = state_q;
        lvl_d              = lvl_q;
        is_instr_d         = is_instr_q;
        global_d           = global_q;
        asid_d             = asid_q;
        vaddr_d            = vaddr_q;
        pptr_d             = pptr_q;
        itlb_valid         = 1'b0;
        dtlb_valid         = 1'b0;
        ptw_error_o        = 1'b0;
        ptw_access_fault_o = 1'b0;
        itlb_miss_o        = 1'b0;
        dtlb_miss_o        = 1'b0;

        case (state_q)
            IDLE: begin
                lvl_d    = LVL1;
                global_d = 1'b0;
                if (data_miss) begin
                    is_instr_d  = 1'b0;
                    asid_d      = asid_i;
                    vaddr_d     = dtlb_miss_i.vaddr;
                    pptr_d      = {satp_ppn_i, dtlb_miss_i.vaddr[`PTW_VLEN-1:30], 3'b000};
                    dtlb_miss_o = 1'b1;
                    state_d     = WAIT_GRANT;
                end else if (instr_miss) begin
                    is_instr_d  = 1'b1;
                    asid_d      = asid_i;
                    vaddr_d     = itlb_miss_i.vaddr;
                    pptr_d      = {satp_ppn_i, itlb_miss_i.vaddr[`PTW_VLEN-1:30], 3'b000};
                    itlb_miss_o = 1'b1;
                    state_d     = WAIT_GRANT;
                end
            end

            WAIT_GRANT: begin
                if (mem_rsp_i.gnt) begin
                    state_d = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    global_d = global_q || pte.g;
                    // a denied read overrides whatever the entry says
                    if (!allow_i) begin
                        state_d = PROPAGATE_ACCESS_ERROR;
                    end else if (verdict_i.is_fault) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (verdict_i.is_leaf) begin
                        itlb_valid = is_instr_q;
                        dtlb_valid = !is_instr_q;
                        state_d    = IDLE;
                    end else begin
                        // pointer, descend with the next vpn field
                        state_d = WAIT_GRANT;
                        if (lvl_q == LVL1) begin
                            lvl_d  = LVL2;
                            pptr_d = {pte.ppn, vaddr_q[29:21], 3'b000};
                        end else begin
                            lvl_d  = LVL3;
                            pptr_d = {pte.ppn, vaddr_q[20:12], 3'b000};
                        end
                    end
                end
            end

            WAIT_RVALID: begin
                if (rvalid_q) begin
                    state_d = IDLE;
                end
            end

            PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = IDLE;
            end

            PROPAGATE_ACCESS_ERROR: begin
                ptw_access_fault_o = 1'b1;
                state_d            = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // ------------------------------
        // flush
        // ------------------------------
        // drop all results, but drain a granted read that is still open
        if (flush_i) begin
            itlb_valid         = 1'b0;
            dtlb_valid         = 1'b0;
            ptw_error_o        = 1'b0;
            ptw_access_fault_o = 1'b0;
            itlb_miss_o        = 1'b0;
            dtlb_miss_o        = 1'b0;
            if ((state_q == WAIT_GRANT && mem_rsp_i.gnt) ||
                (state_q == PTE_LOOKUP && !rvalid_q) ||
                (state_q == WAIT_RVALID && !rvalid_q)) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            lvl_q      <= LVL1;
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            is_instr_q <= is_instr_d;
            global_q   <= global_d;
            rvalid_q   <= mem_rsp_i.rvalid;
        end
    end

    always_ff @(posedge clk_i) begin
        asid_q  <= asid_d;
        vaddr_q <= vaddr_d;
        pptr_q  <= pptr_d;
        rdata_q <= mem_rsp_i.rdata;
    end

    // ------------------------------
    // assertions
    // ------------------------------
    // an ungranted request keeps its address until the cache takes it
    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.req && !mem_rsp_i.gnt && !flush_i |=>
            mem_req_o.req && $stable(mem_req_o.addr));

    // one walk serves exactly one tlb
    single_update: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(itlb_update_o.valid && dtlb_update_o.valid));

endmodule

// ==== source/ptw_top.sv ====
// page table walker top level joining the walk fsm with the entry and pmp checkers
`timescale 1ns/1ns
`include "ptw_settings.svh"

module ptw_top import ptw_pkg::*; (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic                                  flush_i,
    // tlb lookups and csr state
    input  tlb_miss_t                             itlb_miss_i,
    input  tlb_miss_t                             dtlb_miss_i,
    input  logic                                  en_instr_i,
    input  logic                                  en_data_i,
    input  logic [`PTW_PPNW-1:0]                  satp_ppn_i,
    input  logic [`PTW_ASIDW-1:0]                 asid_i,
    input  logic                                  mxr_i,
    input  logic                                  lsu_is_store_i,
    input  pmp_entry_t [`PTW_PMP_ENTRIES-1:0]     pmp_cfg_i,
    // data cache port
    output mem_req_t                              mem_req_o,
    input  mem_rsp_t                              mem_rsp_i,
    // results
    output tlb_update_t                           itlb_update_o,
    output tlb_update_t                           dtlb_update_o,
    output logic                                  ptw_active_o,
    output logic                                  ptw_error_o,
    output logic                                  ptw_access_fault_o,
    output logic [`PTW_PLEN-1:0]                  bad_paddr_o,
    output logic                                  itlb_miss_o,
    output logic                                  dtlb_miss_o
);

    pte_t                 pte;
    walk_lvl_t            lvl;
    logic                 is_instr;
    logic [`PTW_PLEN-1:0] pptr;
    pte_verdict_t         verdict;
    logic                 allow;

    walk_sequencer u_sequencer (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .flush_i            (flush_i),
        .itlb_miss_i        (itlb_miss_i),
        .dtlb_miss_i        (dtlb_miss_i),
        .en_instr_i         (en_instr_i),
        .en_data_i          (en_data_i),
        .satp_ppn_i         (satp_ppn_i),
        .asid_i             (asid_i),
        .mem_rsp_i          (mem_rsp_i),
        .verdict_i          (verdict),
        .allow_i            (allow),
        .mem_req_o          (mem_req_o),
        .pte_o              (pte),
        .lvl_o              (lvl),
        .is_instr_o         (is_instr),
        .pptr_o             (pptr),
        .itlb_update_o      (itlb_update_o),
        .dtlb_update_o      (dtlb_update_o),
        .ptw_active_o       (ptw_active_o),
        .ptw_error_o        (ptw_error_o),
        .ptw_access_fault_o (ptw_access_fault_o),
        .bad_paddr_o        (bad_paddr_o),
        .itlb_miss_o        (itlb_miss_o),
        .dtlb_miss_o        (dtlb_miss_o)
    );

    // both checkers judge the registered entry in the same cycle
    pte_checker u_pte_checker (
        .pte_i      (pte),
        .lvl_i      (lvl),
        .is_instr_i (is_instr),
        .is_store_i (lsu_is_store_i),
        .mxr_i      (mxr_i),
        .verdict_o  (verdict)
    );

    pmp_checker u_pmp_checker (
        .addr_i  (pptr),
        .cfg_i   (pmp_cfg_i),
        .allow_o (allow)
    );

endmodule

// ==== tests/ptw_ref_model.svh ====
// page table image builder, tor pmp model and reference sv39 walk for the walker testbench
`ifndef PTW_REF_MODEL_SVH
`define PTW_REF_MODEL_SVH

localparam logic [`PTW_PPNW-1:0] ROOT_PPN = 44'h800;

// sparse memory image, unmapped words read as zero
logic [63:0] image [logic [`PTW_PLEN-1:0]];

// ------------------------------
// image builder
// ------------------------------
// kind 0 clean, 1 invalid, 2 write-only, 3 no a, 4 no w or d, 5 misaligned,
// 6 pointer as leaf, 7 execute-only, 8 pmp denial
task automatic build_image(input logic [`PTW_VLEN-1:0] va, input int leaf_lvl, input int kind);
    logic [`PTW_PPNW-1:0] tbl [3];
    logic [`PTW_PLEN-1:0] addr [3];
    logic [`PTW_PLEN-1:0] hi;
    pte_t                 e;
    int                   deny;
    image.delete();
    tbl[0] = ROOT_PPN;
    tbl[1] = 44'h900 + 44'(rand_bits(8));
    tbl[2] = 44'ha00 + 44'(rand_bits(8));
    for (int l = 0; l < 3; l++) begin
        addr[l] = {tbl[l], va[38-9*l -: 9], 3'b000};
    end
    for (int l = 0; l < leaf_lvl; l++) begin
        e     = '0;
        e.v   = 1'b1;
        e.g   = (rand_bits(2) == 0);
        e.ppn = tbl[l+1];
        image[addr[l]] = e;
    end
    e     = '0;
    {e.d, e.a, e.x, e.w, e.r, e.v} = 6'b111111;
    e.g   = (rand_bits(2) == 0);
    e.ppn = 44'(rand_bits(32));
    if (leaf_lvl == 0) e.ppn[17:0] = '0;
    if (leaf_lvl == 1) e.ppn[8:0] = '0;
    case (kind)
        1: e.v = 1'b0;
        2: {e.x, e.w, e.r} = 3'b010;
        3: e.a = 1'b0;
        4: if (rand_bits(1) != 0) e.w = 1'b0; else e.d = 1'b0;
        5: e.ppn[0] = 1'b1;
        6: {e.x, e.w, e.r} = 3'b000;
        7: {e.x, e.w, e.r} = 3'b100;
        default: ;
    endcase
    image[addr[leaf_lvl]] = e;
    // readable region below the denied word, unreadable region over it
    pmp_cfg = '0;
    if (kind == 8) begin
        deny = (rand_bits(1) != 0) ? leaf_lvl : 0;
        hi   = addr[deny] + 8;
        pmp_cfg[0].r    = 1'b1;
        pmp_cfg[0].addr = addr[deny][`PTW_PLEN-1:2];
        pmp_cfg[1].addr = hi[`PTW_PLEN-1:2];
    end
endtask

function automatic bit pmp_reads_ok(input logic [`PTW_PLEN-1:0] a);
    logic [`PTW_PLEN-1:0] lo;
    logic [`PTW_PLEN-1:0] hi;
    lo = '0;
    for (int k = 0; k < `PTW_PMP_ENTRIES; k++) begin
        hi = {pmp_cfg[k].addr, 2'b00};
        if (a >= lo && a < hi) return pmp_cfg[k].r;
        lo = hi;
    end
    return 1'b1;
endfunction

// ------------------------------
// reference walk
// ------------------------------
// outcome 0 update, 1 page fault, 2 access fault
task automatic model_walk(input logic [`PTW_VLEN-1:0] va, input bit instr, input bit store,
                          input bit mxr, input logic [`PTW_ASIDW-1:0] asid,
                          output int outcome, output tlb_update_t upd,
                          output logic [`PTW_PLEN-1:0] bad);
    logic [`PTW_PPNW-1:0] ppn;
    logic [`PTW_PLEN-1:0] a;
    pte_t                 e;
    bit                   g;
    ppn     = ROOT_PPN;
    g       = 1'b0;
    upd     = '0;
    bad     = '0;
    outcome = 1;
    for (int l = 0; l < 3; l++) begin
        a = {ppn, va[38-9*l -: 9], 3'b000};
        if (!pmp_reads_ok(a)) begin
            outcome = 2;
            bad     = a;
            return;
        end
        if (image.exists(a)) e = pte_t'(image[a]);
        else e = '0;
        g = g | e.g;
        if (!e.v || (e.w && !e.r)) return;
        if (!e.r && !e.x) begin
            if (l == 2) return;
            ppn = e.ppn;
        end else begin
            if (instr && (!e.x || !e.a)) return;
            if (!instr && (!e.a || !(e.r || (mxr && e.x)))) return;
            if (!instr && store && (!e.w || !e.d)) return;
            if (l == 0 && e.ppn[17:0] != '0) return;
            if (l == 1 && e.ppn[8:0] != '0) return;
            outcome         = 0;
            upd.valid       = 1'b1;
            upd.vpn         = va[38:12];
            upd.is_1g       = (l == 0);
            upd.is_2m       = (l == 1);
            upd.asid        = asid;
            upd.content     = e;
            upd.content.g   = g;
            return;
        end
    end
endtask

`endif

// ==== tests/tb_ptw.sv ====
// clock, lfsr, memory responder, compare tasks, stimulus and summary for the walker testbench
`timescale 1ns/1ns
`include "ptw_settings.svh"

module tb_ptw import ptw_pkg::*; ();

    localparam int NUM_WALKS = 300;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic flush_i, en_instr_i, en_data_i, mxr_i, lsu_is_store_i;
    tlb_miss_t itlb_miss_i, dtlb_miss_i;
    logic [`PTW_PPNW-1:0] satp_ppn_i;
    logic [`PTW_ASIDW-1:0] asid_i;
    pmp_entry_t [`PTW_PMP_ENTRIES-1:0] pmp_cfg;
    mem_req_t mem_req_o;
    mem_rsp_t mem_rsp;
    tlb_update_t itlb_update_o, dtlb_update_o;
    logic ptw_active_o, ptw_error_o, ptw_access_fault_o, itlb_miss_o, dtlb_miss_o;
    logic [`PTW_PLEN-1:0] bad_paddr_o;

    logic [31:0] lfsr = 32'hf3af;
    int update_errs = 0;
    int fault_errs = 0;
    int miss_errs = 0;
    int other_errs = 0;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    `include "ptw_ref_model.svh"

    ptw_top u_dut (
        .clk_i, .rst_ni, .flush_i, .itlb_miss_i, .dtlb_miss_i, .en_instr_i, .en_data_i,
        .satp_ppn_i, .asid_i, .mxr_i, .lsu_is_store_i, .pmp_cfg_i(pmp_cfg), .mem_req_o,
        .mem_rsp_i(mem_rsp), .itlb_update_o, .dtlb_update_o, .ptw_active_o, .ptw_error_o,
        .ptw_access_fault_o, .bad_paddr_o, .itlb_miss_o, .dtlb_miss_o
    );

    always #10 clk_i = !clk_i;

    // ------------------------------
    // memory responder
    // ------------------------------
    int gnt_wait = 0;
    int rsp_wait = 0;
    bit pending = 1'b0;
    logic [`PTW_PLEN-1:0] pend_addr;

    always @(negedge clk_i) begin
        mem_rsp.gnt    = 1'b0;
        mem_rsp.rvalid = 1'b0;
        if (!rst_ni) begin
            pending = 1'b0;
        end else if (pending) begin
            if (rsp_wait == 0) begin
                mem_rsp.rvalid = 1'b1;
                mem_rsp.rdata  = image.exists(pend_addr) ? image[pend_addr] : 64'h0;
                pending        = 1'b0;
            end else begin
                rsp_wait--;
            end
        end else if (mem_req_o.req) begin
            if (gnt_wait == 0) begin
                mem_rsp.gnt = 1'b1;
                pending     = 1'b1;
                pend_addr   = mem_req_o.addr;
                rsp_wait    = int'(rand_bits(2) % 3);
                gnt_wait    = int'(rand_bits(2));
            end else begin
                gnt_wait--;
            end
        end
    end

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_update(input tlb_update_t exp, input bit instr);
        tlb_update_t got;
        tlb_update_t other;
        got   = instr ? itlb_update_o : dtlb_update_o;
        other = instr ? dtlb_update_o : itlb_update_o;
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            update_errs++;
            $display("ERROR %0t %s exp %h got %h", $time,
                     instr ? "itlb_update_o" : "dtlb_update_o", exp, got);
        end
        if (other.valid !== 1'b0) begin
            update_errs++;
            $display("update appeared on the tlb that did not miss at %0t", $time);
        end
    endtask

    task automatic check_fault(input int exp_kind, input logic [`PTW_PLEN-1:0] exp_bad);
        int got_kind;
        got_kind = ptw_access_fault_o ? 2 : (ptw_error_o ? 1 : 0);
        if (got_kind != exp_kind) begin
            fault_errs++;
            $display("ERROR %0t walk_outcome exp %0d got %0d", $time, exp_kind, got_kind);
        end
        // zero unless the access fault pulses
        if (bad_paddr_o !== exp_bad) begin
            fault_errs++;
            $display("ERROR %0t bad_paddr_o exp %h got %h", $time, exp_bad, bad_paddr_o);
        end
    endtask

    task automatic check_miss(input logic [1:0] exp);
        if ({dtlb_miss_o, itlb_miss_o} !== exp) begin
            miss_errs++;
            $display("ERROR %0t {dtlb_miss_o,itlb_miss_o} exp %b got %b", $time, exp,
                     {dtlb_miss_o, itlb_miss_o});
        end
    endtask

    task automatic check_active(input logic exp);
        if (ptw_active_o !== exp) begin
            other_errs++;
            $display("ERROR %0t ptw_active_o exp %b got %b", $time, exp, ptw_active_o);
        end
    endtask

    task automatic check_quiet();
        if (itlb_update_o.valid || dtlb_update_o.valid || ptw_error_o || ptw_access_fault_o) begin
            other_errs++;
            $display("walk produced a result after a flush at %0t", $time);
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        logic [`PTW_VLEN-1:0] va;
        int inject, leaf_lvl, exp_kind, flush_gap;
        bit instr, store, mxr, both, flush_walk;
        tlb_update_t exp_upd;
        logic [`PTW_PLEN-1:0] exp_bad;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        itlb_miss_i = '0;
        dtlb_miss_i = '0;
        en_instr_i = 1'b1;
        en_data_i = 1'b1;
        satp_ppn_i = ROOT_PPN;
        asid_i = '0;
        mxr_i = 1'b0;
        lsu_is_store_i = 1'b0;
        pmp_cfg = '0;
        mem_rsp = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int n = 0; n < NUM_WALKS; n++) begin
            @(negedge clk_i);
            check_active(1'b0);
            va[38:32] = 7'(rand_bits(7));
            va[31:0] = rand_bits(32);
            inject = int'(rand_bits(4));
            if (inject > 8) inject = 0;
            leaf_lvl = int'(rand_bits(2) % 3);
            if (inject == 6) leaf_lvl = 2;
            if (inject == 5) leaf_lvl = int'(rand_bits(1));
            both = (rand_bits(3) == 0);
            flush_walk = (rand_bits(3) == 0);
            flush_gap = int'(rand_bits(1));
            instr = both ? 1'b0 : rand_bits(1) != 0;
            store = rand_bits(1) != 0;
            mxr = rand_bits(1) != 0;
            asid_i = rand_bits(16);
            build_image(va, leaf_lvl, inject);
            model_walk(va, instr, store, mxr, asid_i, exp_kind, exp_upd, exp_bad);
            mxr_i = mxr;
            lsu_is_store_i = store;
            if (both) begin
                dtlb_miss_i = {2'b10, va};
                itlb_miss_i = {2'b10, ~va};
            end else if (instr) begin
                itlb_miss_i = {2'b10, va};
            end else begin
                dtlb_miss_i = {2'b10, va};
            end
            @(posedge clk_i);
            check_miss(instr ? 2'b01 : 2'b10);
            @(negedge clk_i);
            itlb_miss_i = '0;
            dtlb_miss_i = '0;
            if (flush_walk) begin
                repeat (flush_gap) @(negedge clk_i);
                flush_i = 1'b1;
                @(posedge clk_i);
                check_quiet();
                @(negedge clk_i);
                flush_i = 1'b0;
                @(posedge clk_i);
                check_quiet();
                while (ptw_active_o) begin
                    @(posedge clk_i);
                    check_quiet();
                end
            end else begin
                do @(posedge clk_i);
                while (!(itlb_update_o.valid || dtlb_update_o.valid ||
                         ptw_error_o || ptw_access_fault_o));
                check_active(1'b1);
                check_fault(exp_kind, exp_bad);
                check_update(exp_upd, instr);
            end
        end
        @(negedge clk_i);
        $display("errors: update %0d fault %0d miss %0d other %0d",
                 update_errs, fault_errs, miss_errs, other_errs);
        if (update_errs + fault_errs + miss_errs + other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog sized from the walk count
    initial begin
        #(NUM_WALKS * 40 * 20);
        $display("watchdog expired before all walks finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
+incdir+tests
source/ptw_pkg.sv
source/pte_checker.sv
source/pmp_checker.sv
source/walk_sequencer.sv
source/ptw_top.sv
tests/tb_ptw.sv

// ==== Makefile ====
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ptw -f verilog.f
	out=$$(./obj_dir/Vtb_ptw); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
